/* compile.f */
src/frame_geom_pkg.sv
src/axi_rd_pkg.sv
src/fifo_wr_if.sv
src/frame_burst_reader.sv
src/line_fifo.sv
src/frame_reader_top.sv
dv/axi_mem_model.sv
dv/tb_frame_reader.sv

/* Bender.yml */
package:
  name: frame_reader

sources:
  - src/frame_geom_pkg.sv
  - src/axi_rd_pkg.sv
  - src/fifo_wr_if.sv
  - src/frame_burst_reader.sv
  - src/line_fifo.sv
  - src/frame_reader_top.sv
  - target: test
    files:
      - dv/axi_mem_model.sv
      - dv/tb_frame_reader.sv

/* dv/tb_frame_reader.sv */
`timescale 1ns/1ps

module tb_frame_reader;

	localparam int CLK_PERIOD_NS = 40;
	localparam int IMG_WIDTH = 64;
	localparam int IMG_HEIGHT = 4;
	localparam int WORDS_PER_LINE = IMG_WIDTH / frame_geom_pkg::PIXELS_PER_WORD;
	localparam int FRAME_WORDS = WORDS_PER_LINE * IMG_HEIGHT;
	localparam axi_rd_pkg::axi_addr_t BASE_ADDR = 32'h0000_1000;
	localparam int TIMEOUT_NS = FRAME_WORDS * 3 * 20 * CLK_PERIOD_NS + 50_000;

	logic M_AXI_ACLK;
	logic M_AXI_ARESETN;
	logic soft_resetn;
	logic resetting;
	frame_geom_pkg::img_width_t img_width;
	frame_geom_pkg::img_height_t img_height;
	logic fsync;
	axi_rd_pkg::axi_addr_t base_addr;
	logic frame_pulse;
	axi_rd_pkg::axi_addr_t M_AXI_ARADDR;
	logic M_AXI_ARVALID;
	logic M_AXI_ARREADY;
	axi_rd_pkg::axi_data_t M_AXI_RDATA;
	logic [1:0] M_AXI_RRESP;
	logic M_AXI_RLAST;
	logic M_AXI_RVALID;
	logic M_AXI_RREADY;
	logic rd_en;
	axi_rd_pkg::axi_data_t dout;
	logic sof;
	logic eol;
	logic empty;

	axi_rd_pkg::axi_addr_t mem_rd_addr;
	logic [31:0] rnd = 32'hcddeaace;
	logic mem_slow;
	int pop_odds;
	int word_idx;
	int pulse_count = 0;
	string test_name;

	// ----------------------------------------
	// Reference model
	// ----------------------------------------

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Memory contents mixed from every address bit
	function automatic axi_rd_pkg::axi_data_t mem_word(input axi_rd_pkg::axi_addr_t addr);
		return {addr[15:0], addr[31:16]} ^ (addr * 32'h045d_9f3b) ^ 32'h3c6e_f372;
	endfunction

	function automatic axi_rd_pkg::axi_data_t exp_data(input int idx);
		return mem_word(BASE_ADDR + axi_rd_pkg::axi_addr_t'(idx * 4));
	endfunction

	function automatic logic exp_eol(input int idx);
		return (idx % WORDS_PER_LINE) == WORDS_PER_LINE - 1;
	endfunction

	// ----------------------------------------
	// Checks
	// ----------------------------------------

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Checks failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_word(input string name, input axi_rd_pkg::axi_data_t exp,
		input axi_rd_pkg::axi_data_t act);
		if (exp !== act)
			stop_on_error($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act)
			stop_on_error($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (exp != act)
			stop_on_error($sformatf("CHECK FAILED %s expected %0d actual %0d", name, exp, act));
	endtask

	// ----------------------------------------
	// DUT and memory
	// ----------------------------------------

	frame_reader_top DUT (.*);

	axi_mem_model u_mem (
		.clk (M_AXI_ACLK),
		.rstn (M_AXI_ARESETN),
		.slow (mem_slow),
		.rnd (rnd),
		.araddr (M_AXI_ARADDR),
		.arvalid (M_AXI_ARVALID),
		.arready (M_AXI_ARREADY),
		.rresp (M_AXI_RRESP),
		.rlast (M_AXI_RLAST),
		.rvalid (M_AXI_RVALID),
		.rready (M_AXI_RREADY),
		.rd_addr (mem_rd_addr)
	);

	assign M_AXI_RDATA = mem_word(mem_rd_addr);

	initial begin
		M_AXI_ACLK = 1'b0;
		forever #(CLK_PERIOD_NS / 2) M_AXI_ACLK = ~M_AXI_ACLK;
	end

	always @(negedge M_AXI_ACLK)
		rnd <= xorshift(rnd);

	always @(negedge M_AXI_ACLK)
		if (M_AXI_ARESETN && frame_pulse)
			pulse_count <= pulse_count + 1;

	// Consumer with random pops that checks each word as it leaves
	initial begin
		rd_en = 1'b0;
		forever begin
			@(negedge M_AXI_ACLK);
			if (rd_en && !empty) begin
				if (word_idx >= FRAME_WORDS) begin
					stop_on_error($sformatf("%s popped a word past the end of the frame",
						test_name));
				end else begin
					check_word($sformatf("%s data %0d", test_name, word_idx),
						exp_data(word_idx), dout);
					check_flag($sformatf("%s sof %0d", test_name, word_idx),
						word_idx == 0, sof);
					check_flag($sformatf("%s eol %0d", test_name, word_idx),
						exp_eol(word_idx), eol);
					word_idx++;
				end
			end
			@(posedge M_AXI_ACLK);
			#2;
			rd_en = (int'(rnd[15:12]) < pop_odds);
		end
	end

	initial begin
		#(TIMEOUT_NS);
		stop_on_error("Timeout: the frame reader stopped delivering data");
	end

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------

	task automatic send_fsync();
		@(posedge M_AXI_ACLK);
		#2;
		fsync = 1'b0;
		@(posedge M_AXI_ACLK);
		#2;
		fsync = 1'b1;
	endtask

	task automatic run_frame(input string name, input int odds, input logic slow);
		test_name = name;
		pop_odds = odds;
		mem_slow = slow;
		word_idx = 0;
		send_fsync();
		wait (word_idx == FRAME_WORDS);
		repeat (4) @(negedge M_AXI_ACLK);
		check_flag({name, " empty after frame"}, 1'b1, empty);
	endtask

	// Abandon a frame part way and drain what was already queued
	task automatic soft_reset_frame();
		test_name = "soft_reset";
		pop_odds = 6;
		mem_slow = 1'b0;
		word_idx = 0;
		send_fsync();
		wait (word_idx >= 20);
		@(posedge M_AXI_ACLK);
		#2;
		soft_resetn = 1'b0;
		@(posedge M_AXI_ACLK);
		#2;
		soft_resetn = 1'b1;
		@(negedge M_AXI_ACLK);
		check_flag("soft_reset resetting raised", 1'b1, resetting);
		wait (resetting == 1'b0);
		@(negedge M_AXI_ACLK);
		check_flag("soft_reset arvalid after burst", 1'b0, M_AXI_ARVALID);
		check_flag("soft_reset rready after burst", 1'b0, M_AXI_RREADY);
		while (!empty)
			@(negedge M_AXI_ACLK);
		repeat (4) @(negedge M_AXI_ACLK);
		check_flag("soft_reset fifo drained", 1'b1, empty);
	endtask

	initial begin
		M_AXI_ARESETN = 1'b0;
		soft_resetn = 1'b1;
		fsync = 1'b1;
		img_width = frame_geom_pkg::img_width_t'(IMG_WIDTH);
		img_height = frame_geom_pkg::img_height_t'(IMG_HEIGHT);
		base_addr = BASE_ADDR;
		mem_slow = 1'b0;
		pop_odds = 16;
		word_idx = 0;
		test_name = "reset";
		repeat (5) @(posedge M_AXI_ACLK);
		#2;
		check_flag("reset empty", 1'b1, empty);
		M_AXI_ARESETN = 1'b1;
		wait (resetting == 1'b0);

		run_frame("frame_repeat_1", 16, 1'b0);
		run_frame("frame_repeat_2", 10, 1'b0);
		run_frame("back_pressure", 2, 1'b1);
		check_count("frame_pulse after three frames", 3, pulse_count);
		soft_reset_frame();
		run_frame("frame_after_soft_reset", 12, 1'b0);
		check_count("frame_pulse total", 5, pulse_count);

		$display("All checks passed");
		$finish;
	end

endmodule

/* dv/axi_mem_model.sv */
`timescale 1ns/1ps

// AXI4 read responder, one burst at a time, with random stalls
module axi_mem_model (
	input logic clk,
	input logic rstn,
	input logic slow,
	input logic [31:0] rnd,
	input axi_rd_pkg::axi_addr_t araddr,
	input logic arvalid,
	output logic arready,
	output logic [1:0] rresp,
	output logic rlast,
	output logic rvalid,
	input logic rready,
	// Byte address of the beat currently on RDATA
	output axi_rd_pkg::axi_addr_t rd_addr
);

	axi_rd_pkg::axi_addr_t burst_base;
	int beat;
	logic active;
	logic ar_fire;
	logic r_fire;

	initial begin
		arready = 1'b0;
		rvalid = 1'b0;
		active = 1'b0;
		beat = 0;
		burst_base = '0;
		ar_fire = 1'b0;
		r_fire = 1'b0;
	end

	// Handshakes seen mid-cycle complete at the next rising edge
	always @(negedge clk) begin
		ar_fire = arvalid && arready;
		r_fire = rvalid && rready;
		if (ar_fire)
			burst_base = araddr;
	end

	always @(posedge clk) begin
		#2;
		if (!rstn) begin
			active = 1'b0;
			beat = 0;
			arready = 1'b0;
			rvalid = 1'b0;
		end else begin
			if (ar_fire) begin
				active = 1'b1;
				beat = 0;
			end else if (r_fire) begin
				if (beat == axi_rd_pkg::BURST_LEN - 1)
					active = 1'b0;
				else
					beat = beat + 1;
			end
			arready = !active && (rnd[1:0] != 2'b00);
			// RVALID holds until the beat is taken
			if (!(rvalid && !r_fire))
				rvalid = active && (slow ? (rnd[3:2] == 2'b00) : (rnd[3:2] != 2'b00));
		end
	end

	assign rresp = 2'b00;
	assign rlast = active && (beat == axi_rd_pkg::BURST_LEN - 1);
	assign rd_addr = burst_base + axi_rd_pkg::axi_addr_t'(beat * 4);

endmodule

/* src/frame_reader_top.sv */
`timescale 1ns/1ps

module frame_reader_top (
	input logic M_AXI_ACLK,
	input logic M_AXI_ARESETN,

	// Frame controls
	input logic soft_resetn,
	output logic resetting,
	input frame_geom_pkg::img_width_t img_width,
	input frame_geom_pkg::img_height_t img_height,
	input logic fsync,
	input axi_rd_pkg::axi_addr_t base_addr,
	output logic frame_pulse,

	// AXI4 read address channel
	output axi_rd_pkg::axi_addr_t M_AXI_ARADDR,
	output logic M_AXI_ARVALID,
	input logic M_AXI_ARREADY,

	// AXI4 read data channel
	input axi_rd_pkg::axi_data_t M_AXI_RDATA,
	input logic [1:0] M_AXI_RRESP,
	input logic M_AXI_RLAST,
	input logic M_AXI_RVALID,
	output logic M_AXI_RREADY,

	// FIFO read side
	input logic rd_en,
	output axi_rd_pkg::axi_data_t dout,
	output logic sof,
	output logic eol,
	output logic empty
);

	fifo_wr_if fifo_wr ();

	frame_burst_reader u_reader (
		.M_AXI_ACLK (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.soft_resetn (soft_resetn),
		.resetting (resetting),
		.img_width (img_width),
		.img_height (img_height),
		.fsync (fsync),
		.base_addr (base_addr),
		.frame_pulse (frame_pulse),
		.M_AXI_ARADDR (M_AXI_ARADDR),
		.M_AXI_ARVALID (M_AXI_ARVALID),
		.M_AXI_ARREADY (M_AXI_ARREADY),
		.M_AXI_RDATA (M_AXI_RDATA),
		.M_AXI_RRESP (M_AXI_RRESP),
		.M_AXI_RLAST (M_AXI_RLAST),
		.M_AXI_RVALID (M_AXI_RVALID),
		.M_AXI_RREADY (M_AXI_RREADY),
		.wr (fifo_wr.writer)
	);

	line_fifo u_fifo (
		.M_AXI_ACLK (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.wr (fifo_wr.reader),
		.rd_en (rd_en),
		.dout (dout),
		.sof (sof),
		.eol (eol),
		.empty (empty)
	);

endmodule

/* src/line_fifo.sv */
`timescale 1ns/1ps

module line_fifo (
	input logic M_AXI_ACLK,
	input logic M_AXI_ARESETN,

	fifo_wr_if.reader wr,

	// Consumer side, first word fall through
	input logic rd_en,
	output axi_rd_pkg::axi_data_t dout,
	output logic sof,
	output logic eol,
	output logic empty
);

	axi_rd_pkg::axi_data_t mem_data [axi_rd_pkg::FIFO_DEPTH];
	logic mem_sof [axi_rd_pkg::FIFO_DEPTH];
	logic mem_eol [axi_rd_pkg::FIFO_DEPTH];

	// Depth is a power of two so pointers wrap on their own
	logic [$clog2(axi_rd_pkg::FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(axi_rd_pkg::FIFO_DEPTH)-1:0] rd_ptr;
	axi_rd_pkg::fifo_count_t count;

	logic do_wr;
	logic do_rd;

	assign do_wr = wr.wr_en && !wr.full;
	// Pop on empty is ignored
	assign do_rd = rd_en && !empty;

	// ----------------------------------------
	// Storage
	// ----------------------------------------

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			for (int i = 0; i < axi_rd_pkg::FIFO_DEPTH; i++) begin
				mem_data[i] <= '0;
				mem_sof[i] <= 1'b0;
				mem_eol[i] <= 1'b0;
			end
		end else if (do_wr) begin
			mem_data[wr_ptr] <= wr.dout;
			mem_sof[wr_ptr] <= wr.sof;
			mem_eol[wr_ptr] <= wr.eol;
		end
	end

	// ----------------------------------------
	// Pointers and fill level
	// ----------------------------------------

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			unique case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign wr.wr_data_count = count;
	assign wr.full = (count == axi_rd_pkg::fifo_count_t'(axi_rd_pkg::FIFO_DEPTH));
	assign empty = (count == '0);

	// Head word is visible as soon as it is written
	assign dout = mem_data[rd_ptr];
	assign sof = mem_sof[rd_ptr];
	assign eol = mem_eol[rd_ptr];

	// The reader's space check keeps a whole burst below capacity
	no_write_when_full_a: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		wr.wr_en |-> !wr.full);

endmodule

/* src/frame_burst_reader.sv */
`timescale 1ns/1ps

module frame_burst_reader (
	input logic M_AXI_ACLK,
	input logic M_AXI_ARESETN,

	// Frame controls
	input logic soft_resetn,
	output logic resetting,
	input frame_geom_pkg::img_width_t img_width,
	input frame_geom_pkg::img_height_t img_height,
	input logic fsync,
	input axi_rd_pkg::axi_addr_t base_addr,
	output logic frame_pulse,

	// Read address channel
	output axi_rd_pkg::axi_addr_t M_AXI_ARADDR,
	output logic M_AXI_ARVALID,
	input logic M_AXI_ARREADY,

	// Read data channel
	input axi_rd_pkg::axi_data_t M_AXI_RDATA,
	input logic [1:0] M_AXI_RRESP,
	input logic M_AXI_RLAST,
	input logic M_AXI_RVALID,
	output logic M_AXI_RREADY,

	fifo_wr_if.writer wr
);

	typedef enum logic [1:0] {
		st_idle,
		st_addr,
		st_data
	} rd_state_t;

	rd_state_t state;

	logic fsync_q;
	logic fsync_fall;
	logic soft_resetn_q;
	logic soft_fall;
	logic start_burst;
	logic start_ok;
	logic space_ok;
	logic final_data;
	logic rnext;
	logic sof_q;
	axi_rd_pkg::axi_addr_t araddr;
	frame_geom_pkg::img_width_t col_cnt;
	frame_geom_pkg::img_height_t row_cnt;
	frame_geom_pkg::img_width_t col_reload;

	// ----------------------------------------
	// Edge detection
	// ----------------------------------------

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			fsync_q <= 1'b0;
			fsync_fall <= 1'b0;
			soft_resetn_q <= 1'b0;
		end else begin
			fsync_q <= fsync;
			fsync_fall <= fsync_q & ~fsync;
			soft_resetn_q <= soft_resetn;
		end
	end

	assign soft_fall = soft_resetn_q & ~soft_resetn;

	// Soft reset holds until the burst in flight has drained
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN)
			resetting <= 1'b1;
		else if (soft_fall)
			resetting <= 1'b1;
		else if (state == st_idle && !start_burst)
			resetting <= 1'b0;
		else if (rnext && M_AXI_RLAST)
			resetting <= 1'b0;
	end

	// ----------------------------------------
	// Burst control
	// ----------------------------------------

	assign rnext = M_AXI_RVALID && M_AXI_RREADY;
	assign final_data = (col_cnt == '0) && (row_cnt == '0);

	// A whole burst must fit before it is issued
	assign space_ok = wr.wr_data_count < axi_rd_pkg::fifo_count_t'(axi_rd_pkg::BURST_LEN);

	assign start_ok = (state == st_idle) && !start_burst && soft_resetn_q && !resetting
		&& space_ok;

	// New frame accepted this cycle
	assign frame_pulse = start_ok && final_data && fsync_fall;

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN)
			start_burst <= 1'b0;
		else
			start_burst <= start_ok && (!final_data || fsync_fall);
	end

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			state <= st_idle;
		end else begin
			unique case (state)
				st_idle: if (start_burst) state <= st_addr;
				st_addr: if (M_AXI_ARREADY) state <= st_data;
				st_data: if (rnext && M_AXI_RLAST) state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	// Frame start rewinds to base_addr, otherwise step one burst
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN)
			araddr <= '0;
		else if (start_burst)
			araddr <= final_data ? base_addr
				: araddr + axi_rd_pkg::axi_addr_t'(axi_rd_pkg::BURST_BYTES);
	end

	assign M_AXI_ARADDR = araddr;
	assign M_AXI_ARVALID = (state == st_addr);
	assign M_AXI_RREADY = (state == st_data);

	// ----------------------------------------
	// Frame position and flags
	// ----------------------------------------

	assign col_reload = img_width
		- frame_geom_pkg::img_width_t'(frame_geom_pkg::PIXELS_PER_WORD);

	// Counters hold the position of the next word to arrive
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN || resetting) begin
			col_cnt <= '0;
			row_cnt <= '0;
		end else if (start_burst && final_data) begin
			col_cnt <= col_reload;
			row_cnt <= img_height - 1'b1;
		end else if (rnext) begin
			if (col_cnt != '0) begin
				col_cnt <= col_cnt
					- frame_geom_pkg::img_width_t'(frame_geom_pkg::PIXELS_PER_WORD);
			end else if (row_cnt != '0) begin
				col_cnt <= col_reload;
				row_cnt <= row_cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN || resetting)
			sof_q <= 1'b0;
		else if (start_burst && final_data)
			sof_q <= 1'b1;
		else if (rnext)
			sof_q <= 1'b0;
	end

	assign wr.dout = M_AXI_RDATA;
	assign wr.sof = sof_q;
	// Last word of a line has no columns left
	assign wr.eol = (col_cnt == '0);
	assign wr.wr_en = rnext && !resetting;

	// ----------------------------------------
	// Protocol checks
	// ----------------------------------------

	araddr_stable_a: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		(M_AXI_ARVALID && !M_AXI_ARREADY) |=> (M_AXI_ARVALID && $stable(M_AXI_ARADDR)));

	// Data only for a burst whose address was accepted
	rvalid_issued_a: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		M_AXI_RVALID |-> (state == st_data));

	rresp_okay_a: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		rnext |-> !M_AXI_RRESP[1]);

endmodule

/* src/fifo_wr_if.sv */
`timescale 1ns/1ps

// Write side between the burst reader and the line FIFO
interface fifo_wr_if;
	axi_rd_pkg::axi_data_t dout;
	logic sof;
	logic eol;
	logic wr_en;
	logic full;
	axi_rd_pkg::fifo_count_t wr_data_count;

	// Burst reader pushes words and watches the fill level
	modport writer (
		output dout, sof, eol, wr_en,
		input full, wr_data_count
	);

	// FIFO takes words and reports its state back
	modport reader (
		input dout, sof, eol, wr_en,
		output full, wr_data_count
	);

endinterface

/* src/axi_rd_pkg.sv */
package axi_rd_pkg;

	// ----------------------------------------
	// AXI4 read channel types
	// ----------------------------------------

	// Byte address on ARADDR
	typedef logic [31:0] axi_addr_t;

	// One RDATA beat
	typedef logic [31:0] axi_data_t;

	// ----------------------------------------
	// Fixed burst shape
	// ----------------------------------------

	// INCR bursts of 4-byte beats, ARLEN is BURST_LEN - 1
	localparam int BURST_LEN = 16;

	// Address step from one burst to the next
	localparam int BURST_BYTES = BURST_LEN * 4;

	// ----------------------------------------
	// Line FIFO
	// ----------------------------------------

	// Capacity in words, two bursts deep
	localparam int FIFO_DEPTH = 32;

	// Fill level, wide enough to hold FIFO_DEPTH itself
	typedef logic [5:0] fifo_count_t;

endpackage

/* src/frame_geom_pkg.sv */
package frame_geom_pkg;

	// ----------------------------------------
	// Image geometry
	// ----------------------------------------

	// Image width in pixels
	// Must be a whole number of data words
	typedef logic [11:0] img_width_t;

	// Image height in lines
	typedef logic [11:0] img_height_t;

	// ----------------------------------------
	// Pixel packing
	// ----------------------------------------

	// Pixels packed into one 32-bit data word, one byte each
	// The column counter steps by this amount per beat
	localparam int PIXELS_PER_WORD = 4;

	// Width of 64 pixels gives 16 words per line, i.e. one burst per line
	// Total frame size must be a whole number of bursts

endpackage
